// ==== Makefile ====
# Verilator build and run for the control unit testbench

VERILATOR ?= verilator
TOP       ?= controlUnit_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard hdl/*.sv tb/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
test: $(SIM)
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
hdl/mipsCtrlPkg.sv
hdl/funcDecode.sv
hdl/opDecode.sv
hdl/controlUnit.sv
tb/controlUnit_tb.sv

// ==== hdl/controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decode stage with one register on the output
module controlUnit (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [mipsCtrlPkg::instrWidth-1:0] instr,
	input  logic                                instrValid, // One-cycle strobe
	output mipsCtrlPkg::ctrlWord_t              ctrl,
	output logic                                ctrlValid
);
	import mipsCtrlPkg::*;

	opcode_t   opField;
	funct_t    functField;
	logic      rotSel;    // Bit 21
	logic      rotVarSel; // Bit 6
	logic      sebSehSel; // Bit 9
	ctrlWord_t rWord;     // R-type candidate
	ctrlWord_t nextCtrl;  // Final combinational word

	// Field slicing
	assign opField    = instr[opMsb:opLsb];
	assign functField = instr[functMsb:functLsb];
	assign rotSel     = instr[rotBit];
	assign rotVarSel  = instr[rotVarBit];
	assign sebSehSel  = instr[sebSehBit];

	funcDecode u_funcDecode (
		.funct       (functField),
		.rotBitIn    (rotSel),
		.rotVarBitIn (rotVarSel),
		.rWord       (rWord)
	);

	opDecode u_opDecode (
		.opcode      (opField),
		.funct       (functField),
		.sebSehBitIn (sebSehSel),
		.rWord       (rWord),
		.nextCtrl    (nextCtrl)
	);

	// Output stage
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl      <= ctrlDefault;
			ctrlValid <= 1'b0;
		end else begin
			ctrlValid <= instrValid; // Exactly one cycle behind
			if (instrValid) begin
				ctrl <= nextCtrl; // Held while idle
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/funcDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

// R-type decode from the function field alone
module funcDecode (
	input  mipsCtrlPkg::funct_t    funct,       // Instruction bits 5:0
	input  logic                   rotBitIn,    // Instruction bit 21
	input  logic                   rotVarBitIn, // Instruction bit 6
	output mipsCtrlPkg::ctrlWord_t rWord
);
	import mipsCtrlPkg::*;

	always_comb begin
		// Start from AND, every R-type writes rd
		rWord = ctrlDefault;

		case (funct)
			// Plain arithmetic and logic
			fnAdd:  rWord.aluOp = aluAdd;
			fnAddu: rWord.aluOp = aluAddu; // No overflow trap
			fnSub:  rWord.aluOp = aluSub;
			fnAnd:  rWord.aluOp = aluAnd;
			fnOr:   rWord.aluOp = aluOr;
			fnXor:  rWord.aluOp = aluXor;
			fnNor:  rWord.aluOp = aluNor;
			fnSlt:  rWord.aluOp = aluSlt;
			fnSltu: rWord.aluOp = aluSltu;

			// Immediate shift count comes from shamt
			fnSll: begin
				rWord.aluSrc1 = 1'b1;
				rWord.aluOp   = aluShl;
			end
			fnSrlRotr: begin
				rWord.aluSrc1 = 1'b1;
				// Bit 21 set means rotr
				if (rotBitIn) begin
					rWord.aluOp = aluRotr;
				end else begin
					rWord.aluOp = aluShr;
				end
			end
			fnSra: begin
				rWord.aluSrc1 = 1'b1;
				rWord.aluOp   = aluSra; // Arithmetic right
			end

			// Variable shifts take the count from rs
			fnSllv: rWord.aluOp = aluShl;
			fnSrlvRotrv: begin
				if (rotVarBitIn) begin // rotrv
					rWord.aluOp = aluRotr;
				end else begin
					rWord.aluOp = aluShr; // srlv
				end
			end
			fnSrav: rWord.aluOp = aluSra;

			// Conditional moves
			fnMovn: begin
				rWord.condMov = 1'b1; // Write only if rt nonzero
				rWord.aluOp   = aluMovn;
			end
			fnMovz: begin
				rWord.condMov = 1'b1; // Write only if rt zero
				rWord.aluOp   = aluMovz;
			end

			// Multiplier results go to hi/lo only
			fnMult: begin
				rWord.regWrite = 1'b0;
				rWord.aluOp    = aluMult;
			end
			fnMultu: begin
				rWord.regWrite = 1'b0;
				rWord.aluOp    = aluMultu;
			end
			fnMthi: begin
				rWord.regWrite = 1'b0; // Loads hi from rs
				rWord.aluOp    = aluMovHi;
			end
			fnMtlo: begin
				rWord.regWrite = 1'b0; // Loads lo from rs
				rWord.aluOp    = aluMovLo;
			end

			// Reads from hi/lo do land in rd
			fnMfhi: rWord.aluOp = aluMfhi;
			fnMflo: rWord.aluOp = aluMflo;

			// Unknown codes keep the AND word
			default: rWord = ctrlDefault;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/mipsCtrlPkg.sv ====
`default_nettype none

package mipsCtrlPkg;

	// Datapath and field sizes
	localparam int instrWidth = 32;
	localparam int fieldWidth = 6; // Opcode and function fields share a width

	// Opcode field sits on top of the word
	localparam int opMsb = 31;
	localparam int opLsb = 26;

	// Function field at the bottom
	localparam int functMsb = 5;
	localparam int functLsb = 0;

	// Extra bits that split instructions sharing one encoding
	localparam int rotBit    = 21; // High for rotr, low for srl
	localparam int rotVarBit = 6;  // High for rotrv, low for srlv
	localparam int sebSehBit = 9;  // High for seh, low for seb

	typedef logic [fieldWidth-1:0] opcode_t;
	typedef logic [fieldWidth-1:0] funct_t;

	// Primary opcodes still decoded
	localparam opcode_t opRType    = 6'b000000;
	localparam opcode_t opAddi     = 6'b001000;
	localparam opcode_t opAddiu    = 6'b001001;
	localparam opcode_t opSlti     = 6'b001010;
	localparam opcode_t opSltiu    = 6'b001011;
	localparam opcode_t opAndi     = 6'b001100;
	localparam opcode_t opOri      = 6'b001101;
	localparam opcode_t opXori     = 6'b001110;
	localparam opcode_t opSpecial2 = 6'b011100; // madd, msub, mul
	localparam opcode_t opSpecial3 = 6'b011111; // seb, seh

	// R-type function codes
	localparam funct_t fnSll       = 6'b000000;
	localparam funct_t fnSrlRotr   = 6'b000010; // Split on bit 21
	localparam funct_t fnSra       = 6'b000011;
	localparam funct_t fnSllv      = 6'b000100;
	localparam funct_t fnSrlvRotrv = 6'b000110; // Split on bit 6
	localparam funct_t fnSrav      = 6'b000111;
	localparam funct_t fnMovz      = 6'b001010;
	localparam funct_t fnMovn      = 6'b001011;
	localparam funct_t fnMfhi      = 6'b010000;
	localparam funct_t fnMthi      = 6'b010001;
	localparam funct_t fnMflo      = 6'b010010;
	localparam funct_t fnMtlo      = 6'b010011;
	localparam funct_t fnMult      = 6'b011000;
	localparam funct_t fnMultu     = 6'b011001;
	localparam funct_t fnAdd       = 6'b100000;
	localparam funct_t fnAddu      = 6'b100001;
	localparam funct_t fnSub       = 6'b100010;
	localparam funct_t fnAnd       = 6'b100100;
	localparam funct_t fnOr        = 6'b100101;
	localparam funct_t fnXor       = 6'b100110;
	localparam funct_t fnNor       = 6'b100111;
	localparam funct_t fnSlt       = 6'b101010;
	localparam funct_t fnSltu      = 6'b101011;

	// SPECIAL2 reuses the function field with its own meaning
	localparam funct_t fnMadd = 6'b000000;
	localparam funct_t fnMul  = 6'b000010;
	localparam funct_t fnMsub = 6'b000100;

	// ALU operation codes as the ALU expects them
	// 10000 to 10101 belonged to branches and stay unused
	typedef enum logic [4:0] {
		aluAnd   = 5'b00000,
		aluOr    = 5'b00001,
		aluAdd   = 5'b00010,
		aluShl   = 5'b00011,
		aluShr   = 5'b00100, // Logical right shift
		aluXor   = 5'b00101,
		aluSub   = 5'b00110,
		aluSlt   = 5'b00111,
		aluNor   = 5'b01000,
		aluMul   = 5'b01001, // Low word into rd
		aluMovHi = 5'b01010, // mthi
		aluMovLo = 5'b01011, // mtlo
		aluMfhi  = 5'b01100,
		aluMflo  = 5'b01101,
		aluMadd  = 5'b01110, // Accumulate into hi/lo
		aluMsub  = 5'b01111,
		aluSeb   = 5'b10110,
		aluSeh   = 5'b10111,
		aluRotr  = 5'b11000,
		aluMovn  = 5'b11001,
		aluMovz  = 5'b11010,
		aluSra   = 5'b11011,
		aluSltu  = 5'b11100,
		aluMultu = 5'b11101,
		aluMult  = 5'b11110,
		aluAddu  = 5'b11111
	} aluOp_t;

	// Control word handed to the datapath
	typedef struct packed {
		logic   regDst;   // 1 writes rd, 0 writes rt
		logic   aluSrc1;  // 1 feeds shamt to ALU port A
		logic   aluSrc2;  // 1 feeds extended immediate to port B
		logic   regWrite; // Register file write enable
		logic   signExt;  // 1 sign extends the immediate
		logic   condMov;  // Gated by ALU zero flag downstream
		aluOp_t aluOp;
	} ctrlWord_t;

	// R-type AND writing rd
	// Also the answer for anything not recognised
	localparam ctrlWord_t ctrlDefault = '{
		regDst:   1'b1,
		aluSrc1:  1'b0,
		aluSrc2:  1'b0,
		regWrite: 1'b1,
		signExt:  1'b0,
		condMov:  1'b0,
		aluOp:    aluAnd
	};

endpackage

`default_nettype wire

// ==== hdl/opDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

// Opcode level decode
// R-type words arrive ready from funcDecode
module opDecode (
	input  mipsCtrlPkg::opcode_t   opcode,      // Instruction bits 31:26
	input  mipsCtrlPkg::funct_t    funct,       // Needed again for SPECIAL2
	input  logic                   sebSehBitIn, // Instruction bit 9
	input  mipsCtrlPkg::ctrlWord_t rWord,
	output mipsCtrlPkg::ctrlWord_t nextCtrl
);
	import mipsCtrlPkg::*;

	always_comb begin
		nextCtrl = ctrlDefault;

		case (opcode)
			opRType: nextCtrl = rWord;

			// I-type ALU ops write rt from rs and the immediate
			opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opSltiu: begin
				nextCtrl.regDst  = 1'b0;
				nextCtrl.aluSrc2 = 1'b1;
				nextCtrl.signExt = 1'b1; // Cleared below for ori/xori

				case (opcode)
					opAddi:  nextCtrl.aluOp = aluAdd;
					opAddiu: nextCtrl.aluOp = aluAddu; // Still sign extended
					opOri: begin
						nextCtrl.signExt = 1'b0; // Zero extended
						nextCtrl.aluOp   = aluOr;
					end
					opXori: begin
						nextCtrl.signExt = 1'b0;
						nextCtrl.aluOp   = aluXor;
					end
					opSlti:  nextCtrl.aluOp = aluSlt;
					opSltiu: nextCtrl.aluOp = aluSltu;
					default: nextCtrl.aluOp = aluAnd; // andi
				endcase
			end

			// Multiply-accumulate group
			opSpecial2: begin
				nextCtrl.regWrite = 1'b0; // Only mul writes rd

				case (funct)
					fnMsub: nextCtrl.aluOp = aluMsub;
					fnMul: begin
						nextCtrl.regWrite = 1'b1;
						nextCtrl.aluOp    = aluMul;
					end
					// madd and unknown codes
					default: nextCtrl.aluOp = aluMadd;
				endcase
			end

			// Sign extend byte or halfword into rd
			opSpecial3: begin
				if (sebSehBitIn) begin
					nextCtrl.aluOp = aluSeh;
				end else begin
					nextCtrl.aluOp = aluSeb;
				end
			end

			// Unknown opcode falls back to AND
			default: nextCtrl = ctrlDefault;
		endcase
	end

endmodule

`default_nettype wire

// ==== tb/controlUnit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnit_tb;
	import mipsCtrlPkg::*;

	localparam int drainLimit = 20;  // Cycles allowed for the pipe to empty
	localparam int mixCycles  = 120;

	// Every R-type function code the decoder knows
	localparam funct_t rtypeFns [23] = '{
		fnAdd, fnAddu, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
		fnMult, fnMultu, fnMthi, fnMtlo, fnMfhi, fnMflo,
		fnSll, fnSrlRotr, fnSllv, fnSrlvRotrv, fnSra, fnSrav, fnMovn, fnMovz
	};
	localparam opcode_t immOps [7] = '{opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opSltiu};

	logic                  clk;
	logic                  rst;
	logic [instrWidth-1:0] instr;
	logic                  instrValid;
	ctrlWord_t             ctrl;
	logic                  ctrlValid;

	logic      checkEn  = 1'b0; // Out of reset as seen at the last rising edge
	logic      expValid = 1'b0; // Strobe captured at the last rising edge
	ctrlWord_t expQ[$];
	string     nameQ[$];
	ctrlWord_t lastCtrl;        // What ctrl must hold while idle
	ctrlWord_t expWord;
	string     expName;

	controlUnit u_dut (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.ctrl       (ctrl),
		.ctrlValid  (ctrlValid)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	function automatic ctrlWord_t makeWord(input logic dst, input logic src1, input logic src2,
		input logic wr, input logic sext, input logic cmov, input aluOp_t op);
		ctrlWord_t w;
		w.regDst   = dst;
		w.aluSrc1  = src1;
		w.aluSrc2  = src2;
		w.regWrite = wr;
		w.signExt  = sext;
		w.condMov  = cmov;
		w.aluOp    = op;
		return w;
	endfunction

	// Expected control word built from the decode rules
	function automatic ctrlWord_t decodeRef(input logic [instrWidth-1:0] w);
		opcode_t   op;
		funct_t    fn;
		ctrlWord_t c;
		op = w[opMsb:opLsb];
		fn = w[functMsb:functLsb];
		c  = makeWord(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, aluAnd); // R-type AND
		case (op)
			opRType: begin
				case (fn)
					fnAdd:       c.aluOp = aluAdd;
					fnAddu:      c.aluOp = aluAddu;
					fnSub:       c.aluOp = aluSub;
					fnOr:        c.aluOp = aluOr;
					fnXor:       c.aluOp = aluXor;
					fnNor:       c.aluOp = aluNor;
					fnSlt:       c.aluOp = aluSlt;
					fnSltu:      c.aluOp = aluSltu;
					fnMult:      c.aluOp = aluMult;
					fnMultu:     c.aluOp = aluMultu;
					fnMthi:      c.aluOp = aluMovHi;
					fnMtlo:      c.aluOp = aluMovLo;
					fnMfhi:      c.aluOp = aluMfhi;
					fnMflo:      c.aluOp = aluMflo;
					fnSll:       c.aluOp = aluShl;
					fnSllv:      c.aluOp = aluShl;
					fnSrlRotr:   c.aluOp = w[rotBit] ? aluRotr : aluShr;
					fnSrlvRotrv: c.aluOp = w[rotVarBit] ? aluRotr : aluShr;
					fnSra:       c.aluOp = aluSra;
					fnSrav:      c.aluOp = aluSra;
					fnMovn:      c.aluOp = aluMovn;
					fnMovz:      c.aluOp = aluMovz;
					default:     c.aluOp = aluAnd; // and plus unknown codes
				endcase
				c.aluSrc1  = (fn == fnSll) || (fn == fnSrlRotr) || (fn == fnSra); // shamt shifts
				c.condMov  = (fn == fnMovn) || (fn == fnMovz);
				// hi/lo only writers
				c.regWrite = !((fn == fnMult) || (fn == fnMultu) || (fn == fnMthi) || (fn == fnMtlo));
			end
			opAddi:  c = makeWord(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, aluAdd);
			opAddiu: c = makeWord(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, aluAddu);
			opAndi:  c = makeWord(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, aluAnd);
			opOri:   c = makeWord(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, aluOr);  // Zero extend
			opXori:  c = makeWord(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, aluXor); // Zero extend
			opSlti:  c = makeWord(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, aluSlt);
			opSltiu: c = makeWord(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, aluSltu);
			opSpecial2: begin
				if (fn == fnMul) begin
					c.aluOp = aluMul;
				end else begin
					c.regWrite = 1'b0; // madd, msub and unknown land in hi/lo
					c.aluOp    = (fn == fnMsub) ? aluMsub : aluMadd;
				end
			end
			opSpecial3: c.aluOp = w[sebSehBit] ? aluSeh : aluSeb;
			default:    c.aluOp = aluAnd; // Unknown opcode
		endcase
		return c;
	endfunction

	function automatic logic isKnownOp(input opcode_t op);
		logic hit;
		hit = (op == opRType) || (op == opSpecial2) || (op == opSpecial3);
		for (int k = 0; k < 7; k++) begin
			if (immOps[k] == op) hit = 1'b1;
		end
		return hit;
	endfunction

	function automatic logic isKnownFunct(input funct_t fn);
		logic hit;
		hit = 1'b0;
		for (int k = 0; k < 23; k++) begin
			if (rtypeFns[k] == fn) hit = 1'b1;
		end
		return hit;
	endfunction

	// Random word with the opcode forced
	function automatic logic [instrWidth-1:0] randWithOp(input opcode_t op);
		logic [instrWidth-1:0] w;
		w = $urandom;
		w[opMsb:opLsb] = op;
		return w;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			failRun($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic sendInstr(input logic [instrWidth-1:0] word, input string name);
		@(negedge clk);
		instr      = word;
		instrValid = 1'b1;
		expQ.push_back(decodeRef(word));
		nameQ.push_back(name);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(negedge clk);
			instrValid = 1'b0;
			instr      = $urandom; // Junk on the bus must not leak through
		end
	endtask

	always @(posedge clk) begin
		checkEn  <= !rst;
		expValid <= instrValid && !rst;
	end

	// Outputs settle after the rising edge, so look at the falling one
	always @(negedge clk) begin
		if (!checkEn) begin
			lastCtrl = makeWord(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, aluAnd);
		end else if (expValid && !ctrlValid) begin
			failRun("A strobe was not followed by ctrlValid on the next edge");
		end else if (!expValid && ctrlValid) begin
			failRun("ctrlValid went high without a strobe one cycle before");
		end else if (ctrlValid) begin
			if (expQ.size() == 0) begin
				failRun("ctrlValid arrived with no expected control word queued");
			end else begin
				expWord  = expQ.pop_front();
				expName  = nameQ.pop_front();
				checkValue(expName, 32'(expWord), 32'(ctrl));
				lastCtrl = expWord;
			end
		end else begin
			checkValue("idle hold", 32'(lastCtrl), 32'(ctrl)); // No strobe means no change
		end
	end

	initial begin
		logic [instrWidth-1:0] word;
		opcode_t               op;
		funct_t                fn;
		int                    gap;
		int                    sel;
		int                    waitCycles;
		void'($urandom(32'h0202_7fcd));
		rst        = 1'b1;
		instr      = '0;
		instrValid = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkValue("reset ctrlValid", 32'd0, 32'(ctrlValid));
		checkValue("reset ctrl", 32'(makeWord(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, aluAnd)),
			32'(ctrl));

		// Whole R-type table as one back-to-back burst
		// Bits 21 and 6 walk all four combinations independently
		for (int i = 0; i < 23; i++) begin
			for (int b = 0; b < 4; b++) begin
				word = randWithOp(opRType);
				word[functMsb:functLsb] = rtypeFns[i];
				word[rotBit]    = b[0];
				word[rotVarBit] = b[1];
				sendInstr(word, $sformatf("rtype funct %02h bit21=%0d bit6=%0d",
					rtypeFns[i], b[0], b[1]));
			end
		end
		idleCycles(3);

		for (int i = 0; i < 7; i++) begin
			sendInstr(randWithOp(immOps[i]), $sformatf("immediate opcode %02h", immOps[i]));
			gap = int'($urandom % 3); // Zero to two idle cycles
			idleCycles(gap);
		end

		word = randWithOp(opSpecial2);
		word[functMsb:functLsb] = fnMadd;
		sendInstr(word, "special2 madd");
		word[functMsb:functLsb] = fnMsub;
		sendInstr(word, "special2 msub");
		word[functMsb:functLsb] = fnMul;
		sendInstr(word, "special2 mul");
		for (int b = 0; b < 4; b++) begin
			word = randWithOp(opSpecial3);
			word[sebSehBit] = b[0];
			sendInstr(word, $sformatf("special3 bit9=%0d", b[0]));
		end
		idleCycles(2);

		// Fallback paths
		for (int i = 0; i < 30; i++) begin
			op = opcode_t'($urandom);
			while (isKnownOp(op)) op = opcode_t'($urandom);
			sendInstr(randWithOp(op), $sformatf("unknown opcode %02h", op));
		end
		for (int i = 0; i < 30; i++) begin
			fn = funct_t'($urandom);
			while (isKnownFunct(fn)) fn = funct_t'($urandom);
			word = randWithOp(opRType);
			word[functMsb:functLsb] = fn;
			sendInstr(word, $sformatf("unknown rtype funct %02h", fn));
		end
		for (int i = 0; i < 20; i++) begin
			fn = funct_t'($urandom);
			while (fn == fnMadd || fn == fnMsub || fn == fnMul) fn = funct_t'($urandom);
			word = randWithOp(opSpecial2);
			word[functMsb:functLsb] = fn;
			sendInstr(word, $sformatf("unknown special2 funct %02h", fn));
		end
		idleCycles(4);

		// Mixed traffic with random idle cycles
		for (int i = 0; i < mixCycles; i++) begin
			if ($urandom % 2 == 0) begin
				sel  = int'($urandom % 4);
				word = $urandom;
				case (sel)
					0: begin
						word[opMsb:opLsb] = opRType;
						word[functMsb:functLsb] = rtypeFns[int'($urandom % 23)];
					end
					1: word[opMsb:opLsb] = immOps[int'($urandom % 7)];
					2: word[opMsb:opLsb] = ($urandom % 2 == 0) ? opSpecial2 : opSpecial3;
					default: ; // Fully random word
				endcase
				sendInstr(word, "mixed stream");
			end else begin
				idleCycles(1);
			end
		end

		idleCycles(1);
		waitCycles = 0;
		while (expQ.size() != 0) begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > drainLimit) begin
				failRun("Timed out waiting for the remaining control words");
			end
		end
		idleCycles(3); // A few more hold checks

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
